//--- Makefile
TOP = tb_cw_io_shell

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f cw_io_shell.f

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -qx "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

//--- capture_trigger.sv
//////////////////////////////
// One-shot scope trigger qualified by engine busy
//////////////////////////////
`timescale 1ns/10ps

module capture_trigger (
  input  logic clk,
  input  logic reset_i,
  input  logic trig_req_i,     // Software trigger from the core
  input  logic engine_busy_i,  // Crypto engine not idle
  output logic trig_o          // To the trigger pad
);

  logic armed_q;  // Request may still fire
  logic trig_q;

  // Trigger tracks busy during the first busy window of a request only
  always_ff @(posedge clk) begin
    if (reset_i) begin
      armed_q <= 1'b0;
      trig_q  <= 1'b0;
    end else begin
      if (!trig_req_i) begin
        armed_q <= 1'b1;                 // Re-arm once request drops
      end else if (trig_q && !engine_busy_i) begin
        armed_q <= 1'b0;                 // Busy window over, capture done
      end
      trig_q <= armed_q & trig_req_i & engine_busy_i;
    end
  end

  assign trig_o = trig_q;

endmodule

//--- cw_io_shell.f
+incdir+.
pad_map_pkg.sv
jtag_pkg.sv
pad_io_if.sv
pad_ring.sv
jtag_overlay.sv
capture_trigger.sv
cw_io_shell.sv
tb_clkgen.sv
tb_cw_io_shell.sv

//--- cw_io_shell.sv
//////////////////////////////
// I/O shell top: capture trigger, JTAG overlay,
// pad ring and mio/dio split
//////////////////////////////
`timescale 1ns/10ps
`include "io_consts.svh"

module cw_io_shell (
  input  logic                               clk,
  input  logic                               reset_i,
  // Board pads
  input  logic [`NUM_MIO-1:0]                mio_pad_in_i,
  output logic [`NUM_MIO-1:0]                mio_pad_out_o,
  output logic [`NUM_MIO-1:0]                mio_pad_oe_o,
  input  logic [`NUM_DIO-1:0]                dio_pad_in_i,
  output logic [`NUM_DIO-1:0]                dio_pad_out_o,
  output logic [`NUM_DIO-1:0]                dio_pad_oe_o,
  // Core side
  input  logic [`NUM_MIO-1:0]                mio_out_core_i,
  input  logic [`NUM_MIO-1:0]                mio_oe_core_i,
  output logic [`NUM_MIO-1:0]                mio_in_core_o,
  input  logic [`NUM_DIO-1:0]                dio_out_core_i,
  input  logic [`NUM_DIO-1:0]                dio_oe_core_i,
  output logic [`NUM_DIO-1:0]                dio_in_core_o,
  input  logic [`NUM_MIO-1:0][`ATTR_W-1:0]   mio_attr_i,
  input  logic [`NUM_DIO-1:0][`ATTR_W-1:0]   dio_attr_i,
  // JTAG port toward the core
  output logic                               jtag_tck_o,
  output logic                               jtag_tms_o,
  output logic                               jtag_tdi_o,
  output logic                               jtag_trst_n_o,
  output logic                               jtag_srst_n_o,
  input  logic                               jtag_tdo_i,
  input  logic                               engine_busy_i
);

  pad_io_if core_side ();  // Core to overlay
  pad_io_if pad_side ();   // Overlay to pad ring

  logic               trig;      // Qualified capture trigger
  logic [`NUM_MIO-1:0] mio_out;  // Core mio out with trigger swapped in
  logic [`NUM_IO-1:0]  pad_out;
  logic [`NUM_IO-1:0]  pad_oe;

  //////////////////////////////
  // Capture trigger
  //////////////////////////////

  capture_trigger u_capture_trigger (
    .clk           (clk),
    .reset_i       (reset_i),
    .trig_req_i    (mio_out_core_i[`MIO_TRIGGER]),
    .engine_busy_i (engine_busy_i),
    .trig_o        (trig)
  );

  for (genvar i = 0; i < `NUM_MIO; i++) begin : gen_mio_out
    if (i == `MIO_TRIGGER) begin : gen_trig
      assign mio_out[i] = trig;  // Registered, one cycle behind the core
    end else begin : gen_pass
      assign mio_out[i] = mio_out_core_i[i];
    end
  end

  // Dio above mio in every full-width vector
  assign core_side.out  = {dio_out_core_i, mio_out};
  assign core_side.oe   = {dio_oe_core_i, mio_oe_core_i};
  assign core_side.attr = {dio_attr_i, mio_attr_i};
  assign mio_in_core_o  = core_side.in[`NUM_MIO-1:0];
  assign dio_in_core_o  = core_side.in[`NUM_IO-1:`NUM_MIO];

  //////////////////////////////
  // JTAG overlay and pad ring
  //////////////////////////////

  jtag_overlay u_jtag_overlay (
    .io_core       (core_side),
    .io_pad        (pad_side),
    .jtag_tck_o    (jtag_tck_o),
    .jtag_tms_o    (jtag_tms_o),
    .jtag_tdi_o    (jtag_tdi_o),
    .jtag_trst_n_o (jtag_trst_n_o),
    .jtag_srst_n_o (jtag_srst_n_o),
    .jtag_tdo_i    (jtag_tdo_i)
  );

  pad_ring u_pad_ring (
    .clk       (clk),
    .reset_i   (reset_i),
    .pad_in_i  ({dio_pad_in_i, mio_pad_in_i}),
    .pad_out_o (pad_out),
    .pad_oe_o  (pad_oe),
    .io        (pad_side)
  );

  // Back to the two pad groups
  assign mio_pad_out_o = pad_out[`NUM_MIO-1:0];
  assign dio_pad_out_o = pad_out[`NUM_IO-1:`NUM_MIO];
  assign mio_pad_oe_o  = pad_oe[`NUM_MIO-1:0];
  assign dio_pad_oe_o  = pad_oe[`NUM_IO-1:`NUM_MIO];

endmodule

//--- io_consts.svh
//////////////////////////////
// Pad counts, attribute width, pad indices
// and connect masks for the I/O shell
//////////////////////////////
`ifndef IO_CONSTS_SVH
`define IO_CONSTS_SVH

// Pad counts, muxed pads sit in the low bits of the full vector
`define NUM_MIO 20
`define NUM_DIO 8
`define NUM_IO (`NUM_MIO + `NUM_DIO)

`define ATTR_W 2               // Attribute bits per pad

// Pads bonded out on the board, unconnected ones read and drive 0
`define MIO_CONNECT 20'hF_F8FF  // MIO 8..10 not bonded
`define DIO_CONNECT 8'h6F       // DIO 4 and 7 not bonded

// Muxed pad indices
`define MIO_TRIGGER 15          // Scope capture trigger
`define MIO_JTAG_EN 16          // Strap, high selects JTAG
`define MIO_JTAG_TRST 18
`define MIO_JTAG_SRST 19

// Dedicated pad indices, SPI device pins shared with JTAG
`define DIO_SCK 0               // TCK in JTAG mode
`define DIO_CSB 1               // TMS
`define DIO_SDI 2               // TDI
`define DIO_SDO 3               // TDO

`define JTAG_NUM_ROLES 6        // Overlaid pins

`endif

//--- jtag_overlay.sv
//////////////////////////////
// JTAG overlay mux, strap selected,
// with core tie-off values
//////////////////////////////
`timescale 1ns/10ps
`include "io_consts.svh"

module jtag_overlay
  import jtag_pkg::*;
(
  pad_io_if.pad  io_core,       // Looks like the pads to the core
  pad_io_if.core io_pad,        // Looks like the core to the pad ring
  output logic   jtag_tck_o,
  output logic   jtag_tms_o,
  output logic   jtag_tdi_o,
  output logic   jtag_trst_n_o,
  output logic   jtag_srst_n_o,
  input  logic   jtag_tdo_i
);

  logic jtag_mode;  // Synchronized strap level

  // Full-vector pad index of each overlaid pin
  function automatic int unsigned role_pad_idx(jtag_role_e role);
    case (role)
      JTAG_TCK:  return `NUM_MIO + `DIO_SCK;
      JTAG_TMS:  return `NUM_MIO + `DIO_CSB;
      JTAG_TDI:  return `NUM_MIO + `DIO_SDI;
      JTAG_TDO:  return `NUM_MIO + `DIO_SDO;
      JTAG_TRST: return `MIO_JTAG_TRST;
      default:   return `MIO_JTAG_SRST;
    endcase
  endfunction

  // Value the core sees on an overlaid pad, CSB is active low so idles high
  function automatic logic role_tie_off(jtag_role_e role);
    return role == JTAG_TMS;
  endfunction

  assign jtag_mode = io_pad.in[`MIO_JTAG_EN];

  //////////////////////////////
  // Pad and core muxing
  //////////////////////////////

  always_comb begin
    io_pad.out = io_core.out;  // Default pass-through
    io_pad.oe  = io_core.oe;
    io_core.in = io_pad.in;
    if (jtag_mode) begin
      for (int r = 0; r < `JTAG_NUM_ROLES; r++) begin
        io_core.in[role_pad_idx(jtag_role_e'(r))] = role_tie_off(jtag_role_e'(r));
        if (jtag_role_drives_pad(jtag_role_e'(r))) begin
          io_pad.out[role_pad_idx(jtag_role_e'(r))] = jtag_tdo_i;
          io_pad.oe[role_pad_idx(jtag_role_e'(r))]  = 1'b1;
        end else begin
          io_pad.oe[role_pad_idx(jtag_role_e'(r))]  = 1'b0;  // Pad is an input
        end
      end
    end
  end

  assign io_pad.attr = io_core.attr;  // Attributes untouched

  //////////////////////////////
  // JTAG port
  //////////////////////////////

  // Idle values outside JTAG mode hold the TAP in reset, system out of reset
  assign jtag_tck_o    = jtag_mode & io_pad.in[`NUM_MIO + `DIO_SCK];
  assign jtag_tms_o    = jtag_mode & io_pad.in[`NUM_MIO + `DIO_CSB];
  assign jtag_tdi_o    = jtag_mode & io_pad.in[`NUM_MIO + `DIO_SDI];
  assign jtag_trst_n_o = jtag_mode & io_pad.in[`MIO_JTAG_TRST];
  assign jtag_srst_n_o = ~jtag_mode | io_pad.in[`MIO_JTAG_SRST];

endmodule

//--- jtag_pkg.sv
//////////////////////////////
// JTAG pin roles and overlay direction
//////////////////////////////

package jtag_pkg;

  // Pins taken over by the overlay while the strap is high
  typedef enum logic [2:0] {
    JTAG_TCK  = 3'd0,  // From SCK pad
    JTAG_TMS  = 3'd1,  // From CSB pad
    JTAG_TDI  = 3'd2,  // From SDI pad
    JTAG_TDO  = 3'd3,  // To SDO pad
    JTAG_TRST = 3'd4,  // From MIO 18
    JTAG_SRST = 3'd5   // From MIO 19
  } jtag_role_e;

  // High when the overlay drives the pad, else the pad is an input
  function automatic logic jtag_role_drives_pad(jtag_role_e role);
    return role == JTAG_TDO;
  endfunction

endpackage

//--- pad_io_if.sv
//////////////////////////////
// Pad bundle: out, oe, in and attributes
//////////////////////////////
`timescale 1ns/10ps
`include "io_consts.svh"

interface pad_io_if;

  logic [`NUM_IO-1:0]              out;   // Value toward the pad
  logic [`NUM_IO-1:0]              oe;    // Output enable toward the pad
  logic [`NUM_IO-1:0]              in;    // Value from the pad
  logic [`NUM_IO-1:0][`ATTR_W-1:0] attr;  // Per-pad attribute word

  //////////////////////////////
  // Modports
  //////////////////////////////

  // Side that owns the pad controls
  modport core (
    output out,
    output oe,
    output attr,
    input  in
  );

  // Side that owns the physical pad
  // The overlay takes this view toward the core
  modport pad (
    input  out,
    input  oe,
    input  attr,
    output in
  );

endinterface

//--- pad_map_pkg.sv
//////////////////////////////
// Pad attribute bit positions
//////////////////////////////

package pad_map_pkg;

  //////////////////////////////
  // Attribute word layout
  //////////////////////////////

  // Bit positions inside one pad's attribute word
  // Invert applies both ways, in and out
  // Open drain lets the pad pull low only
  typedef enum int unsigned {
    ATTR_INVERT     = 0,  // Flip pad polarity
    ATTR_OPEN_DRAIN = 1   // Drive low, release high
  } pad_attr_bit_e;

  // Remaining encodings of a 2-bit word
  //   2'b00  plain push-pull
  //   2'b01  push-pull, inverted
  //   2'b10  open drain
  //   2'b11  open drain, inverted

endpackage

//--- pad_ring.sv
//////////////////////////////
// Pad ring: attributes, connect masks
// and two-flop input synchronizer
//////////////////////////////
`timescale 1ns/10ps
`include "io_consts.svh"

module pad_ring
  import pad_map_pkg::*;
(
  input  logic               clk,
  input  logic               reset_i,
  input  logic [`NUM_IO-1:0] pad_in_i,   // Raw pad levels, async
  output logic [`NUM_IO-1:0] pad_out_o,
  output logic [`NUM_IO-1:0] pad_oe_o,
  pad_io_if.pad              io          // Overlay side
);

  // Bonded pads, dio above mio like the pad vector
  localparam logic [`NUM_IO-1:0] CONNECT = {`DIO_CONNECT, `MIO_CONNECT};

  logic [`NUM_IO-1:0] invert;     // Per-pad invert bit
  logic [`NUM_IO-1:0] open_drain; // Per-pad open drain bit
  logic [`NUM_IO-1:0] out_pol;    // Out after inversion
  logic [`NUM_IO-1:0] sync_q1;    // First sync stage
  logic [`NUM_IO-1:0] sync_q2;    // Second sync stage

  //////////////////////////////
  // Attribute decode
  //////////////////////////////

  always_comb begin
    for (int i = 0; i < `NUM_IO; i++) begin
      invert[i]     = io.attr[i][ATTR_INVERT];
      open_drain[i] = io.attr[i][ATTR_OPEN_DRAIN];
    end
  end

  //////////////////////////////
  // Output path
  //////////////////////////////

  assign out_pol = io.out ^ invert;

  // Open drain pad never drives high, only enables on a low value
  assign pad_out_o = CONNECT & ~open_drain & out_pol;
  assign pad_oe_o  = CONNECT & ((open_drain & io.oe & ~out_pol) |
                                (~open_drain & io.oe));

  //////////////////////////////
  // Input path
  //////////////////////////////

  // Two flops before anything reads the pad
  always_ff @(posedge clk) begin
    if (reset_i) begin
      sync_q1 <= '0;
      sync_q2 <= '0;
    end else begin
      sync_q1 <= pad_in_i;
      sync_q2 <= sync_q1;
    end
  end

  // Polarity fixed after the synchronizer, unbonded pads read 0
  assign io.in = (sync_q2 ^ invert) & CONNECT;

endmodule

//--- tb_clkgen.sv
//////////////////////////////
// Testbench clock and reset
//////////////////////////////
`timescale 1ns/10ps

module tb_clkgen (
  output logic clk_o,
  output logic reset_o
);

  initial begin
    clk_o   = 1'b0;
    reset_o = 1'b1;
    repeat (3) @(posedge clk_o);  // Reset over three rising edges
    @(negedge clk_o);
    reset_o = 1'b0;               // Released on a falling edge
  end

  always #2 clk_o = ~clk_o;       // 4 ns period

endmodule

//--- tb_cw_io_shell.sv
//////////////////////////////
// I/O shell testbench: random stimulus and a
// cycle model of pad ring, overlay and trigger
//////////////////////////////
`timescale 1ns/10ps
`include "io_consts.svh"

module tb_cw_io_shell
  import pad_map_pkg::*, jtag_pkg::*;
();

  // Phases: reset, pass-through, JTAG, trigger, mode switching
  localparam int N_RESET = 5;
  localparam int N_PASS = 300;
  localparam int N_JTAG = 200;
  localparam int N_TRIG = 400;
  localparam int N_SWITCH = 300;
  localparam int MAX_CYCLES = N_RESET + N_PASS + N_JTAG + N_TRIG + N_SWITCH + 100;

  // JTAG port outside JTAG mode: tck, tms, tdi, trst_n, srst_n
  localparam logic [4:0] JTAG_IDLE = 5'b00001;

  logic clk;
  logic reset;
  logic [`NUM_MIO-1:0] mio_pad_in_i, mio_pad_out_o, mio_pad_oe_o;
  logic [`NUM_DIO-1:0] dio_pad_in_i, dio_pad_out_o, dio_pad_oe_o;
  logic [`NUM_MIO-1:0] mio_out_core_i, mio_oe_core_i, mio_in_core_o;
  logic [`NUM_DIO-1:0] dio_out_core_i, dio_oe_core_i, dio_in_core_o;
  logic [`NUM_MIO-1:0][`ATTR_W-1:0] mio_attr_i;
  logic [`NUM_DIO-1:0][`ATTR_W-1:0] dio_attr_i;
  logic jtag_tck_o, jtag_tms_o, jtag_tdi_o, jtag_trst_n_o, jtag_srst_n_o;
  logic jtag_tdo_i;
  logic engine_busy_i;

  logic [`NUM_IO-1:0] sync1_m, sync2_m;      // Model of the synchronizer
  logic armed_m, trig_m;                     // Model of the one-shot trigger
  logic req_hold, busy_hold, strap_hold;     // Slow-moving stimulus levels
  integer seed;
  int errors;
  int cycles = 0;

  tb_clkgen u_tb_clkgen (.clk_o(clk), .reset_o(reset));

  cw_io_shell u_cw_io_shell (.reset_i(reset), .*);

  task automatic report_mismatch(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
    errors++;
    $display("FAILED at time %0t: %s got %h, expected %h", $time, what, got, exp);
  endtask

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  task automatic drive_inputs(input int phase);
    logic [63:0] r1, r2, r3;
    r1 = {$random(seed), $random(seed)};
    r2 = {$random(seed), $random(seed)};
    r3 = {$random(seed), $random(seed)};
    {dio_out_core_i, mio_out_core_i} = r1[27:0];
    {dio_oe_core_i, mio_oe_core_i}   = r1[55:28];
    jtag_tdo_i    = r1[56];
    engine_busy_i = r1[57];
    {dio_pad_in_i, mio_pad_in_i} = r2[27:0];
    {dio_attr_i, mio_attr_i}     = {r2[55:28], r3[27:0]};
    mio_attr_i[`MIO_JTAG_EN]   = '0;    // Strap read with plain polarity
    mio_pad_in_i[`MIO_JTAG_EN] = 1'b0;
    case (phase)
      2: mio_pad_in_i[`MIO_JTAG_EN] = 1'b1;
      3: begin
        if (($random(seed) & 7) == 0) req_hold = ~req_hold;
        if (($random(seed) & 3) == 0) busy_hold = ~busy_hold;
        mio_out_core_i[`MIO_TRIGGER] = req_hold;
        engine_busy_i = busy_hold;
      end
      4: begin
        if (($random(seed) & 7) == 0) strap_hold = ~strap_hold;
        mio_pad_in_i[`MIO_JTAG_EN] = strap_hold;
      end
      default: ;
    endcase
  endtask

  //////////////////////////////
  // Reference model
  //////////////////////////////

  // Registered state, advanced once per rising edge
  task automatic update_model();
    logic req;
    logic trig_next;
    req = mio_out_core_i[`MIO_TRIGGER];
    if (reset) begin
      {sync1_m, sync2_m, armed_m, trig_m} = '0;
    end else begin
      sync2_m   = sync1_m;
      sync1_m   = {dio_pad_in_i, mio_pad_in_i};
      trig_next = armed_m & req & engine_busy_i;
      if (!req) armed_m = 1'b1;                       // Rearm on dropped request
      else if (trig_m && !engine_busy_i) armed_m = 1'b0;  // One capture per request
      trig_m = trig_next;
    end
  endtask

  task automatic check_outputs();
    logic [`NUM_IO-1:0][`ATTR_W-1:0] attr;
    logic [`NUM_IO-1:0] conn, inv, od, pin, exp_in, ov_out, ov_oe, pol;
    logic [4:0] exp_jtag;
    logic mode;
    int unsigned role_pad [`JTAG_NUM_ROLES];
    role_pad = '{`NUM_MIO + `DIO_SCK, `NUM_MIO + `DIO_CSB, `NUM_MIO + `DIO_SDI,
                 `NUM_MIO + `DIO_SDO, `MIO_JTAG_TRST, `MIO_JTAG_SRST};
    attr = {dio_attr_i, mio_attr_i};
    conn = {`DIO_CONNECT, `MIO_CONNECT};
    for (int i = 0; i < `NUM_IO; i++) begin
      inv[i] = attr[i][ATTR_INVERT];
      od[i]  = attr[i][ATTR_OPEN_DRAIN];
    end
    pin    = (sync2_m ^ inv) & conn;  // Synced, polarity fixed, unbonded read 0
    mode   = pin[`MIO_JTAG_EN];
    exp_in = pin;
    ov_out = {dio_out_core_i, mio_out_core_i};
    ov_out[`MIO_TRIGGER] = trig_m;    // Trigger pad lags the core by a cycle
    ov_oe  = {dio_oe_core_i, mio_oe_core_i};
    if (mode) begin
      for (int r = 0; r < `JTAG_NUM_ROLES; r++) begin
        exp_in[role_pad[r]] = (jtag_role_e'(r) == JTAG_TMS);  // CSB idles high
        ov_oe[role_pad[r]]  = (jtag_role_e'(r) == JTAG_TDO);  // Only TDO drives
      end
      ov_out[role_pad[JTAG_TDO]] = jtag_tdo_i;
    end
    pol = ov_out ^ inv;
    if (mode) begin
      exp_jtag = {pin[role_pad[JTAG_TCK]], pin[role_pad[JTAG_TMS]],
                  pin[role_pad[JTAG_TDI]], pin[role_pad[JTAG_TRST]],
                  pin[role_pad[JTAG_SRST]]};
    end else begin
      exp_jtag = JTAG_IDLE;
    end
    if ({dio_pad_out_o, mio_pad_out_o} !== (conn & ~od & pol))
      report_mismatch("pad out", {dio_pad_out_o, mio_pad_out_o}, conn & ~od & pol);
    if ({dio_pad_oe_o, mio_pad_oe_o} !== (conn & ov_oe & ~(od & pol)))
      report_mismatch("pad oe", {dio_pad_oe_o, mio_pad_oe_o}, conn & ov_oe & ~(od & pol));
    if ({dio_in_core_o, mio_in_core_o} !== exp_in)
      report_mismatch("core in", {dio_in_core_o, mio_in_core_o}, exp_in);
    if ({jtag_tck_o, jtag_tms_o, jtag_tdi_o, jtag_trst_n_o, jtag_srst_n_o} !== exp_jtag)
      report_mismatch("jtag port", {jtag_tck_o, jtag_tms_o, jtag_tdi_o,
                      jtag_trst_n_o, jtag_srst_n_o}, exp_jtag);
  endtask

  // One cycle: drive on the falling edge, check, then advance the model
  task automatic step(input int phase);
    @(negedge clk);
    if (phase != 0) drive_inputs(phase);
    #1;
    check_outputs();
    if (phase == 0 && reset) begin
      if ({jtag_tck_o, jtag_tms_o, jtag_tdi_o, jtag_trst_n_o, jtag_srst_n_o} !== JTAG_IDLE)
        report_mismatch("jtag reset value", {jtag_tck_o, jtag_tms_o, jtag_tdi_o,
                        jtag_trst_n_o, jtag_srst_n_o}, JTAG_IDLE);
      if (mio_pad_out_o[`MIO_TRIGGER] !== 1'b0)
        report_mismatch("trigger after reset", mio_pad_out_o[`MIO_TRIGGER], 0);
      if ({dio_in_core_o, mio_in_core_o} !== '0)
        report_mismatch("core in after reset", {dio_in_core_o, mio_in_core_o}, 0);
    end
    @(posedge clk);
    update_model();
  endtask

  initial begin
    seed   = 14;
    errors = 0;
    {mio_out_core_i, mio_oe_core_i, dio_out_core_i, dio_oe_core_i} = '0;
    {mio_attr_i, dio_attr_i, jtag_tdo_i} = '0;
    // Held through reset: pads and strap high, trigger request and busy high
    mio_pad_in_i  = '1;
    dio_pad_in_i  = '1;
    mio_out_core_i[`MIO_TRIGGER] = 1'b1;
    engine_busy_i = 1'b1;
    {req_hold, busy_hold, strap_hold} = '0;
    {sync1_m, sync2_m, armed_m, trig_m} = '0;
    repeat (N_RESET) step(0);
    repeat (N_PASS) step(1);
    repeat (N_JTAG) step(2);
    repeat (N_TRIG) step(3);
    repeat (N_SWITCH) step(4);
    $display("Run done after %0d cycles with %0d errors", cycles, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // Watchdog on the whole run
  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: run still going after %0d cycles", cycles);
      $display("RESULT: FAIL");
      $finish;
    end
  end

endmodule
